// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_parking_gate
FILELIST  := sources.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/gate_cases.txt
// One hex digit per column: kind card1 valid1 card2 valid2 passes dir alarm
// kind 0 entry, 1 exit, 2 full, 3 retry, 4 timeout, 5 emergency, f end; dir 1 entry, 2 exit
03131110
// Exit, car passes
10000120
// Entry refused on a full lot
24141001
// Refused card, then a different valid one
35091110
// Refused card kept until the card window runs out
46060001
// Exit with no passed input, alarm still latched
10000021
// Emergency during card verification
57070000
// Entry with no passed input
0a1a1010
f0000000

// File: dv/tb_parking_gate.sv
`timescale 1ns/100ps

module tb_parking_gate;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      entry_sensor;
    logic                      exit_sensor;
    logic                      entry_passed;
    logic                      exit_passed;
    logic                      parking_full;
    gate_io_pkg::card_id_t     card_id;
    logic                      card_valid;
    logic                      emergency;
    logic                      fee_valid;
    gate_fsm_pkg::gate_state_t current_state;
    logic                      open_entry;
    logic                      open_exit;
    logic                      close_entry;
    logic                      close_exit;
    logic                      alarm;
    logic                      calculate_fee;
    logic                      verify_card;

    logic [31:0] cases [0:31];  // One scenario per word as laid out in the cases file
    int          idle_age;      // Samples spent in idle so far or -1 outside idle

    parking_gate_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic report_and_stop(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic state_is(input gate_fsm_pkg::gate_state_t exp);
        if (current_state !== exp)
            report_and_stop($sformatf("FAILED current_state got %h expected %h",
                                      current_state, exp));
    endtask

    task automatic flag_is(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_and_stop($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    // Outputs are read a quarter period after the falling edge
    task automatic settle();
        #10;
        if (current_state == gate_fsm_pkg::idle)
            idle_age++;
        else
            idle_age = -1;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        settle();
    endtask

    task automatic leave_state(input gate_fsm_pkg::gate_state_t from, input int limit,
                               input string what, output int spent);
        spent = 0;
        while (current_state == from) begin
            spent++;
            if (spent > limit)
                report_and_stop({"Timed out waiting for ", what});
            next_cycle();
        end
    endtask

    task automatic idle_outputs(input logic exp_alarm);
        state_is(gate_fsm_pkg::idle);
        flag_is("close_entry", close_entry, 1'b1);
        flag_is("close_exit", close_exit, 1'b1);
        flag_is("open_entry", open_entry, 1'b0);
        flag_is("open_exit", open_exit, 1'b0);
        flag_is("verify_card", verify_card, 1'b0);
        flag_is("calculate_fee", calculate_fee, 1'b0);
        flag_is("alarm", alarm, exp_alarm);
    endtask

    // Sensor is held until idle has settled and the lane reacts
    task automatic request_lane(input logic entry, input logic full,
                                input gate_io_pkg::card_id_t id, input logic valid);
        @(negedge clk);
        entry_sensor = entry;
        exit_sensor  = !entry;
        parking_full = full;
        card_id      = id;
        card_valid   = valid;
        settle();
        while (idle_age < int'(gate_fsm_pkg::idle_settle_cycles)) begin
            if (idle_age < 0)
                report_and_stop("Lane left idle before the settle time was over");
            flag_is("verify_card", verify_card, 1'b0);
            flag_is("calculate_fee", calculate_fee, 1'b0);
            next_cycle();
        end
        flag_is("verify_card", verify_card, entry && !full);
        flag_is("calculate_fee", calculate_fee, !entry);
        @(negedge clk);
        entry_sensor = 1'b0;
        exit_sensor  = 1'b0;
        parking_full = 1'b0;
        settle();
        flag_is("verify_card", verify_card, 1'b0);  // Requests last one cycle
        flag_is("calculate_fee", calculate_fee, 1'b0);
        if (full) begin
            flag_is("alarm", alarm, 1'b1);
            state_is(gate_fsm_pkg::idle);
        end else if (entry) begin
            state_is(gate_fsm_pkg::card_verification);
        end else begin
            state_is(gate_fsm_pkg::vehicle_detected);
        end
    endtask

    // Open, pass or time out, then close
    task automatic pass_lane(input logic entry, input logic passes);
        int spent;
        state_is(gate_fsm_pkg::open_barrier);
        flag_is("open_entry", open_entry, entry);
        flag_is("open_exit", open_exit, !entry);
        next_cycle();
        state_is(gate_fsm_pkg::vehicle_passing);
        flag_is("open_entry", open_entry, entry);
        flag_is("open_exit", open_exit, !entry);
        @(negedge clk);
        entry_passed = passes && entry;
        exit_passed  = passes && !entry;
        settle();
        @(negedge clk);
        entry_passed = 1'b0;
        exit_passed  = 1'b0;
        settle();
        if (!passes) begin
            leave_state(gate_fsm_pkg::vehicle_passing,
                        int'(gate_fsm_pkg::passing_cycles) + 2, "the passing timeout", spent);
            if (spent + 2 < int'(gate_fsm_pkg::passing_cycles))
                report_and_stop("Barrier closed before the passing time was over");
        end
        state_is(gate_fsm_pkg::close_barrier);
        flag_is("close_entry", close_entry, entry);
        flag_is("close_exit", close_exit, !entry);
        flag_is("open_entry", open_entry, 1'b0);
        flag_is("open_exit", open_exit, 1'b0);
        next_cycle();
    endtask

    initial begin
        logic [31:0] row;
        int          spent;
        int          i;
        reset        = 1'b1;
        entry_sensor = 1'b0;
        exit_sensor  = 1'b0;
        entry_passed = 1'b0;
        exit_passed  = 1'b0;
        parking_full = 1'b0;
        card_id      = '0;
        card_valid   = 1'b0;
        emergency    = 1'b0;
        fee_valid    = 1'b0;
        $readmemh("dv/gate_cases.txt", cases);
        repeat (8) @(negedge clk);
        reset    = 1'b0;
        idle_age = -1;
        settle();
        idle_outputs(1'b0);
        for (i = 0; i < 32; i++) begin
            row = cases[i];
            if (row[31:28] == 4'hf)
                break;
            case (row[31:28])
                4'h0, 4'h3, 4'h4: begin  // Entry, retry and card timeout
                    request_lane(1'b1, 1'b0, row[27:24], row[20]);
                    @(negedge clk);
                    card_id    = row[19:16];
                    card_valid = row[12];
                    settle();
                    if (!row[20])
                        flag_is("alarm", alarm, 1'b1);  // First card refused
                    leave_state(gate_fsm_pkg::card_verification,
                                int'(gate_fsm_pkg::card_window_cycles) + 2,
                                "the end of card verification", spent);
                    if (row[7:4] == 4'h1) begin
                        pass_lane(1'b1, row[8]);
                    end else begin
                        if (spent + 1 < int'(gate_fsm_pkg::card_window_cycles))
                            report_and_stop("Card window ended too early");
                    end
                end
                4'h1: begin
                    request_lane(1'b0, 1'b0, row[27:24], row[20]);
                    repeat (3) begin
                        next_cycle();
                        state_is(gate_fsm_pkg::vehicle_detected);  // No fee yet
                    end
                    @(negedge clk);
                    fee_valid = 1'b1;
                    settle();
                    @(negedge clk);
                    fee_valid = 1'b0;
                    settle();
                    pass_lane(row[7:4] == 4'h1, row[8]);
                end
                4'h2: request_lane(1'b1, 1'b1, row[27:24], row[20]);
                4'h5: begin
                    request_lane(1'b1, 1'b0, row[27:24], row[20]);
                    @(negedge clk);
                    emergency = 1'b1;
                    settle();
                    flag_is("alarm", alarm, !row[20]);
                    repeat (3) begin
                        next_cycle();
                        state_is(gate_fsm_pkg::emergency_mode);
                        flag_is("open_entry", open_entry, 1'b1);
                        flag_is("open_exit", open_exit, 1'b1);
                        flag_is("alarm", alarm, 1'b0);
                    end
                    @(negedge clk);
                    emergency = 1'b0;
                    settle();
                    state_is(gate_fsm_pkg::emergency_mode);
                    next_cycle();
                end
                default: report_and_stop("Unknown scenario kind in the cases file");
            endcase
            idle_outputs(row[0]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: logic/card_checker.sv
`timescale 1ns/100ps

module card_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  gate_fsm_pkg::gate_state_t current_state,
    input  gate_io_pkg::card_id_t     card_id,
    input  logic                      card_valid,
    output logic                      card_accept,
    output logic                      card_reject
);

    logic                  in_verify;
    logic                  was_verifying;  // In verification last cycle
    logic                  accepted;       // Accept seen in this verification
    logic                  check;
    gate_io_pkg::card_id_t last_id;        // Last card that was checked

    assign in_verify = (current_state == gate_fsm_pkg::card_verification);

    // Check on the first verification cycle, then again when the card changes
    assign check = in_verify && !accepted &&
                   (!was_verifying || (card_id != last_id));

    assign card_accept = check && card_valid;
    assign card_reject = check && !card_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            was_verifying <= 1'b0;
            accepted      <= 1'b0;
        end else begin
            was_verifying <= in_verify;
            if (!in_verify)
                accepted <= 1'b0;
            else if (card_accept)
                accepted <= 1'b1;
        end
    end

    // Forgotten once verification is left
    always_ff @(posedge clk) begin
        if (!in_verify)
            last_id <= '0;
        else if (check)
            last_id <= card_id;
    end

    a_one_result: assert property (@(posedge clk) disable iff (reset)
        !(card_accept && card_reject));

endmodule

// File: logic/dwell_timer.sv
`timescale 1ns/100ps

module dwell_timer (
    input  logic                      clk,
    input  logic                      reset,
    input  gate_fsm_pkg::gate_state_t current_state,
    output logic                      dwell_expired
);

    gate_fsm_pkg::gate_state_t prev_state;
    gate_fsm_pkg::tick_t       count_q;
    gate_fsm_pkg::tick_t       count;     // Count as seen in this cycle
    gate_fsm_pkg::tick_t       limit;
    logic                      has_limit;

    // Zero on the first cycle of a new state
    assign count = (current_state != prev_state) ? '0 : count_q;

    always_comb begin
        has_limit = 1'b1;
        limit     = gate_fsm_pkg::passing_cycles;
        case (current_state)
            gate_fsm_pkg::idle:              limit = gate_fsm_pkg::idle_settle_cycles;
            gate_fsm_pkg::vehicle_detected:  limit = gate_fsm_pkg::fee_wait_cycles;
            gate_fsm_pkg::card_verification: limit = gate_fsm_pkg::card_window_cycles;
            gate_fsm_pkg::vehicle_passing:   limit = gate_fsm_pkg::passing_cycles;
            default:                         has_limit = 1'b0;  // Never expires
        endcase
    end

    assign dwell_expired = has_limit && (count >= limit);

    // Longest limit is the saturation point, every limit is reached before it
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_state <= gate_fsm_pkg::idle;
            count_q    <= '0;
        end else begin
            prev_state <= current_state;
            if (count < gate_fsm_pkg::passing_cycles)
                count_q <= count + 10'd1;
            else
                count_q <= count;
        end
    end

    a_count_saturates: assert property (@(posedge clk) disable iff (reset)
        count_q <= gate_fsm_pkg::passing_cycles);

endmodule

// File: logic/gate_fsm_pkg.sv
package gate_fsm_pkg;

    // Lane state, code 3'd7 is unused and falls back to idle
    typedef enum logic [2:0] {
        idle              = 3'd0,
        vehicle_detected  = 3'd1,  // Waiting for the fee
        card_verification = 3'd2,
        open_barrier      = 3'd3,
        vehicle_passing   = 3'd4,
        close_barrier     = 3'd5,
        emergency_mode    = 3'd6
    } gate_state_t;

    // Dwell count in clock cycles
    typedef logic [9:0] tick_t;

    // Settle time before the sensors are looked at in idle
    localparam tick_t idle_settle_cycles = 10'd5;

    // Limit for fee_valid in vehicle_detected
    localparam tick_t fee_wait_cycles = 10'd300;

    // Card window, the driver may retry with another card until then
    localparam tick_t card_window_cycles = 10'd50;

    // Longest a barrier stays open for a passing car
    localparam tick_t passing_cycles = 10'd600;

endpackage

// File: logic/gate_io_pkg.sv
package gate_io_pkg;

    localparam int card_id_w = 4;

    // Identifier read from the card reader
    typedef logic [card_id_w-1:0] card_id_t;

    // Barrier command set for one cycle
    // Open and close are level commands to the barrier drives
    typedef struct packed {
        logic open_entry;
        logic open_exit;
        logic close_entry;
        logic close_exit;
    } barrier_cmd_t;

endpackage

// File: logic/gate_sequencer.sv
`timescale 1ns/100ps

module gate_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      entry_sensor,
    input  logic                      exit_sensor,
    input  logic                      entry_passed,
    input  logic                      exit_passed,
    input  logic                      parking_full,
    input  logic                      fee_valid,
    input  logic                      emergency,
    input  logic                      dwell_expired,
    input  logic                      card_accept,
    input  logic                      card_reject,
    output gate_fsm_pkg::gate_state_t current_state,
    output logic                      open_entry,
    output logic                      open_exit,
    output logic                      close_entry,
    output logic                      close_exit,
    output logic                      alarm,
    output logic                      calculate_fee,
    output logic                      verify_card
);

    gate_fsm_pkg::gate_state_t next_state;
    gate_io_pkg::barrier_cmd_t cmd;
    logic                      entry_dir;     // High for an entry lane
    logic                      start_entry;
    logic                      start_exit;
    logic                      full_refusal;
    logic                      lane_passed;

    assign lane_passed = entry_dir ? entry_passed : exit_passed;

    always_comb begin
        next_state   = current_state;
        start_entry  = 1'b0;
        start_exit   = 1'b0;
        full_refusal = 1'b0;
        if (emergency) begin
            next_state = gate_fsm_pkg::emergency_mode;  // Highest priority
        end else begin
            case (current_state)
                gate_fsm_pkg::idle: begin
                    // Sensors only count once idle has settled
                    if (dwell_expired) begin
                        if (entry_sensor) begin
                            if (parking_full) begin
                                full_refusal = 1'b1;
                            end else begin
                                start_entry = 1'b1;
                                next_state  = gate_fsm_pkg::card_verification;
                            end
                        end else if (exit_sensor) begin
                            start_exit = 1'b1;
                            next_state = gate_fsm_pkg::vehicle_detected;
                        end
                    end
                end
                gate_fsm_pkg::vehicle_detected: begin
                    if (fee_valid)
                        next_state = gate_fsm_pkg::open_barrier;
                    else if (dwell_expired)
                        next_state = gate_fsm_pkg::idle;  // Fee never came
                end
                gate_fsm_pkg::card_verification: begin
                    if (card_accept)
                        next_state = gate_fsm_pkg::open_barrier;
                    else if (dwell_expired)
                        next_state = gate_fsm_pkg::idle;  // Card window over
                end
                gate_fsm_pkg::open_barrier: begin
                    next_state = gate_fsm_pkg::vehicle_passing;
                end
                gate_fsm_pkg::vehicle_passing: begin
                    if (lane_passed || dwell_expired)
                        next_state = gate_fsm_pkg::close_barrier;
                end
                gate_fsm_pkg::close_barrier: begin
                    next_state = gate_fsm_pkg::idle;
                end
                gate_fsm_pkg::emergency_mode: begin
                    next_state = gate_fsm_pkg::idle;  // Emergency released
                end
                default: begin
                    next_state = gate_fsm_pkg::idle;
                end
            endcase
        end
    end

    // Barrier commands follow the state and the lane direction
    always_comb begin
        cmd = '0;
        case (current_state)
            gate_fsm_pkg::idle: begin
                cmd.close_entry = 1'b1;
                cmd.close_exit  = 1'b1;
            end
            gate_fsm_pkg::open_barrier, gate_fsm_pkg::vehicle_passing: begin
                cmd.open_entry = entry_dir;
                cmd.open_exit  = !entry_dir;
            end
            gate_fsm_pkg::close_barrier: begin
                cmd.close_entry = entry_dir;
                cmd.close_exit  = !entry_dir;
            end
            gate_fsm_pkg::emergency_mode: begin
                cmd.open_entry = 1'b1;
                cmd.open_exit  = 1'b1;
            end
            default: begin
                cmd = '0;
            end
        endcase
    end

    assign open_entry    = cmd.open_entry;
    assign open_exit     = cmd.open_exit;
    assign close_entry   = cmd.close_entry;
    assign close_exit    = cmd.close_exit;
    assign verify_card   = start_entry;  // One cycle as idle is left
    assign calculate_fee = start_exit;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_state <= gate_fsm_pkg::idle;
            entry_dir     <= 1'b0;
            alarm         <= 1'b0;
        end else begin
            current_state <= next_state;
            if (start_entry)
                entry_dir <= 1'b1;
            else if (start_exit)
                entry_dir <= 1'b0;
            // Alarm latch cleared by emergency or a good card
            if (emergency || card_accept)
                alarm <= 1'b0;
            else if (card_reject || full_refusal)
                alarm <= 1'b1;
        end
    end

    a_entry_open_close: assert property (@(posedge clk) disable iff (reset)
        !(open_entry && close_entry));

    // A card request is only made from idle
    a_verify_from_idle: assert property (@(posedge clk) disable iff (reset)
        verify_card |-> (current_state == gate_fsm_pkg::idle));

endmodule

// File: logic/parking_gate_top.sv
`timescale 1ns/100ps

module parking_gate_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      entry_sensor,
    input  logic                      exit_sensor,
    input  logic                      entry_passed,
    input  logic                      exit_passed,
    input  logic                      parking_full,
    input  gate_io_pkg::card_id_t     card_id,
    input  logic                      card_valid,
    input  logic                      emergency,
    input  logic                      fee_valid,
    output gate_fsm_pkg::gate_state_t current_state,
    output logic                      open_entry,
    output logic                      open_exit,
    output logic                      close_entry,
    output logic                      close_exit,
    output logic                      alarm,
    output logic                      calculate_fee,
    output logic                      verify_card
);

    logic dwell_expired;  // Level, current state reached its limit
    logic card_accept;    // Pulses from the card check
    logic card_reject;

    gate_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .entry_sensor  (entry_sensor),
        .exit_sensor   (exit_sensor),
        .entry_passed  (entry_passed),
        .exit_passed   (exit_passed),
        .parking_full  (parking_full),
        .fee_valid     (fee_valid),
        .emergency     (emergency),
        .dwell_expired (dwell_expired),
        .card_accept   (card_accept),
        .card_reject   (card_reject),
        .current_state (current_state),
        .open_entry    (open_entry),
        .open_exit     (open_exit),
        .close_entry   (close_entry),
        .close_exit    (close_exit),
        .alarm         (alarm),
        .calculate_fee (calculate_fee),
        .verify_card   (verify_card)
    );

    dwell_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .current_state (current_state),
        .dwell_expired (dwell_expired)
    );

    card_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .current_state (current_state),
        .card_id       (card_id),
        .card_valid    (card_valid),
        .card_accept   (card_accept),
        .card_reject   (card_reject)
    );

endmodule

// File: sources.f
logic/gate_io_pkg.sv
logic/gate_fsm_pkg.sv
logic/dwell_timer.sv
logic/card_checker.sv
logic/gate_sequencer.sv
logic/parking_gate_top.sv
dv/tb_parking_gate.sv
